// File: hw/rename_pkg.sv
// Rename stage types and widths
`default_nettype none

package rename_pkg;

	// Architectural widths
	localparam int ARCH_REGS = 32;
	localparam int ARCH_W = 5;
	localparam int PHYS_W = 6;
	localparam int WORD_W = 32;
	localparam int EX_W = 10;
	localparam int CMD_W = 5;
	localparam int ISSUE_W = 2;

	typedef logic [ARCH_W-1:0] arch_reg_t;
	typedef logic [PHYS_W-1:0] phys_reg_t;

	// Register view of the second source word
	typedef struct packed {
		logic [WORD_W-PHYS_W-1:0] pad;
		logic [PHYS_W-1:0] num;
	} src1_idx_t;

	// Immediate or register index, chosen by src1_imm
	typedef union packed {
		logic [WORD_W-1:0] imm;
		src1_idx_t idx;
	} src1_word_u;

	// Decoded instruction from the upstream stage
	typedef struct packed {
		logic valid;
		logic writeback;
		logic src0_active;
		arch_reg_t src0;
		logic src1_active;
		logic src1_imm;
		src1_word_u src1;
		arch_reg_t dest;
		logic [CMD_W-1:0] cmd;
		logic [EX_W-1:0] ex_unit;	// One-hot unit select
	} rename_inst_t;

	// Captured instruction with its new destination
	typedef struct packed {
		rename_inst_t inst;
		phys_reg_t dest_tag;
	} capture_entry_t;

	// Renamed instruction to the next stage
	typedef struct packed {
		logic valid;
		logic writeback;
		logic src0_active;
		phys_reg_t src0;
		logic src1_active;
		logic src1_imm;
		src1_word_u src1;
		arch_reg_t dest_logic;
		phys_reg_t dest_phys;
		logic [CMD_W-1:0] cmd;
		logic [EX_W-1:0] ex_unit;
	} renamed_inst_t;

	// One map table write port
	typedef struct packed {
		logic en;
		arch_reg_t arch;
		phys_reg_t phys;
	} map_write_t;

endpackage

`default_nettype wire

// File: hw/rename_capture_stage.sv
// Rename capture stage
`default_nettype none

module rename_capture_stage (
	input wire logic iCLOCK,
	input wire logic inRESET,
	input wire logic flush,
	// Upstream
	input wire rename_pkg::rename_inst_t [rename_pkg::ISSUE_W-1:0] prev_inst,
	input wire logic [rename_pkg::WORD_W-1:0] prev_pc,
	output logic prev_lock,
	// Free lists
	input wire rename_pkg::phys_reg_t [rename_pkg::ISSUE_W-1:0] free_tag,
	input wire logic [rename_pkg::ISSUE_W-1:0] free_empty,
	output logic [rename_pkg::ISSUE_W-1:0] free_rd,
	// Downstream
	input wire logic next_lock,
	output logic advance,
	output rename_pkg::capture_entry_t [rename_pkg::ISSUE_W-1:0] cap_entry,
	output logic [rename_pkg::WORD_W-1:0] cap_pc
);

	logic lock;
	logic [rename_pkg::ISSUE_W-1:0] cap_valid;
	rename_pkg::capture_entry_t [rename_pkg::ISSUE_W-1:0] cap_q;

	// Any empty free list or a downstream hold stalls everything
	assign lock = (|free_empty) | next_lock;
	assign prev_lock = lock;
	assign advance = !lock;

	// Pop one tag per writeback slot, consumed at this edge
	always_comb begin
		for (int k = 0; k < rename_pkg::ISSUE_W; k++) begin
			free_rd[k] = prev_inst[k].valid && prev_inst[k].writeback && !lock;
		end
	end

	// Slot valids
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			cap_valid <= '0;
		end else if (flush) begin
			cap_valid <= '0;
		end else if (!lock) begin
			for (int k = 0; k < rename_pkg::ISSUE_W; k++) begin
				cap_valid[k] <= prev_inst[k].valid;
			end
		end
	end

	// Instruction fields, PC and the popped tags
	always_ff @(posedge iCLOCK) begin
		if (!lock) begin
			for (int k = 0; k < rename_pkg::ISSUE_W; k++) begin
				cap_q[k].inst <= prev_inst[k];
				cap_q[k].dest_tag <= free_tag[k];
			end
			cap_pc <= prev_pc;
		end
	end

	always_comb begin
		for (int k = 0; k < rename_pkg::ISSUE_W; k++) begin
			cap_entry[k] = cap_q[k];
			cap_entry[k].inst.valid = cap_valid[k];
		end
	end

endmodule

`default_nettype wire

// File: hw/rename_map_table.sv
// Logical to physical register map
`default_nettype none

module rename_map_table (
	input wire logic iCLOCK,
	input wire logic inRESET,
	input wire logic restart,
	input wire rename_pkg::arch_reg_t [2*rename_pkg::ISSUE_W-1:0] rd_idx,
	output rename_pkg::phys_reg_t [2*rename_pkg::ISSUE_W-1:0] rd_phys,
	input wire rename_pkg::map_write_t [rename_pkg::ISSUE_W-1:0] map_wr
);

	rename_pkg::phys_reg_t map_q [rename_pkg::ARCH_REGS];

	// Identity after reset or restart, later slot wins a shared entry
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int i = 0; i < rename_pkg::ARCH_REGS; i++) begin
				map_q[i] <= rename_pkg::phys_reg_t'(i);
			end
		end else if (restart) begin
			for (int i = 0; i < rename_pkg::ARCH_REGS; i++) begin
				map_q[i] <= rename_pkg::phys_reg_t'(i);
			end
		end else begin
			for (int k = 0; k < rename_pkg::ISSUE_W; k++) begin
				if (map_wr[k].en) begin
					map_q[map_wr[k].arch] <= map_wr[k].phys;
				end
			end
		end
	end

	// Combinational lookups
	always_comb begin
		for (int j = 0; j < 2*rename_pkg::ISSUE_W; j++) begin
			rd_phys[j] = map_q[rd_idx[j]];
		end
	end

endmodule

`default_nettype wire

// File: hw/rename_dispatch_stage.sv
// Rename dispatch stage
`default_nettype none

module rename_dispatch_stage (
	input wire logic iCLOCK,
	input wire logic inRESET,
	input wire logic flush,
	input wire logic advance,
	// From the capture stage
	input wire rename_pkg::capture_entry_t [rename_pkg::ISSUE_W-1:0] cap_entry,
	input wire logic [rename_pkg::WORD_W-1:0] cap_pc,
	// Map table
	output rename_pkg::arch_reg_t [2*rename_pkg::ISSUE_W-1:0] rd_idx,
	input wire rename_pkg::phys_reg_t [2*rename_pkg::ISSUE_W-1:0] rd_phys,
	output rename_pkg::map_write_t [rename_pkg::ISSUE_W-1:0] map_wr,
	// Downstream
	output rename_pkg::renamed_inst_t [rename_pkg::ISSUE_W-1:0] next_inst,
	output logic [rename_pkg::WORD_W-1:0] next_pc
);

	logic slot0_writes;
	logic byp_src0;
	logic byp_src1;
	logic [rename_pkg::ISSUE_W-1:0] out_valid;
	rename_pkg::renamed_inst_t [rename_pkg::ISSUE_W-1:0] renamed;
	rename_pkg::renamed_inst_t [rename_pkg::ISSUE_W-1:0] out_q;

	// Source 0 and source 1 of each slot
	always_comb begin
		for (int k = 0; k < rename_pkg::ISSUE_W; k++) begin
			rd_idx[2*k] = cap_entry[k].inst.src0;
			rd_idx[2*k+1] = cap_entry[k].inst.src1.idx.num[rename_pkg::ARCH_W-1:0];
		end
	end

	// Slot 1 must see the destination slot 0 renames in the same pair
	assign slot0_writes = cap_entry[0].inst.valid && cap_entry[0].inst.writeback;
	assign byp_src0 = slot0_writes && (cap_entry[1].inst.src0 == cap_entry[0].inst.dest);
	assign byp_src1 = slot0_writes && (rd_idx[3] == cap_entry[0].inst.dest);

	always_comb begin
		for (int k = 0; k < rename_pkg::ISSUE_W; k++) begin
			renamed[k].valid = cap_entry[k].inst.valid;
			renamed[k].writeback = cap_entry[k].inst.writeback;
			renamed[k].src0_active = cap_entry[k].inst.src0_active;
			renamed[k].src0 = rd_phys[2*k];
			renamed[k].src1_active = cap_entry[k].inst.src1_active;
			renamed[k].src1_imm = cap_entry[k].inst.src1_imm;
			renamed[k].src1 = cap_entry[k].inst.src1;
			if (!cap_entry[k].inst.src1_imm) begin
				renamed[k].src1.idx.pad = '0;
				renamed[k].src1.idx.num = rd_phys[2*k+1];
			end
			renamed[k].dest_logic = cap_entry[k].inst.dest;
			renamed[k].dest_phys = cap_entry[k].dest_tag;
			renamed[k].cmd = cap_entry[k].inst.cmd;
			renamed[k].ex_unit = cap_entry[k].inst.ex_unit;
		end
		if (byp_src0) begin
			renamed[1].src0 = cap_entry[0].dest_tag;
		end
		if (byp_src1 && !cap_entry[1].inst.src1_imm) begin
			renamed[1].src1.idx.num = cap_entry[0].dest_tag;
		end
	end

	// Table updates as the pair moves on, dropped pairs write nothing
	always_comb begin
		for (int k = 0; k < rename_pkg::ISSUE_W; k++) begin
			map_wr[k].en = advance && !flush && cap_entry[k].inst.valid
				&& cap_entry[k].inst.writeback;
			map_wr[k].arch = cap_entry[k].inst.dest;
			map_wr[k].phys = cap_entry[k].dest_tag;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			out_valid <= '0;
		end else if (flush) begin
			out_valid <= '0;
		end else if (advance) begin
			for (int k = 0; k < rename_pkg::ISSUE_W; k++) begin
				out_valid[k] <= cap_entry[k].inst.valid;
			end
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (advance) begin
			out_q <= renamed;
			next_pc <= cap_pc;
		end
	end

	// A held pair reads invalid
	always_comb begin
		for (int k = 0; k < rename_pkg::ISSUE_W; k++) begin
			next_inst[k] = out_q[k];
			next_inst[k].valid = out_valid[k] && advance;
		end
	end

endmodule

`default_nettype wire

// File: hw/rename_top.sv
// Two-wide register rename stage
`default_nettype none

module rename_top (
	input wire logic iCLOCK,
	input wire logic inRESET,
	// Pipeline control
	input wire logic flush,
	input wire logic restart,
	// Upstream
	input wire rename_pkg::rename_inst_t [rename_pkg::ISSUE_W-1:0] prev_inst,
	input wire logic [rename_pkg::WORD_W-1:0] prev_pc,
	output logic prev_lock,
	// Free list channels
	input wire rename_pkg::phys_reg_t [rename_pkg::ISSUE_W-1:0] free_tag,
	input wire logic [rename_pkg::ISSUE_W-1:0] free_empty,
	output logic [rename_pkg::ISSUE_W-1:0] free_rd,
	// Downstream
	output rename_pkg::renamed_inst_t [rename_pkg::ISSUE_W-1:0] next_inst,
	output logic [rename_pkg::WORD_W-1:0] next_pc,
	input wire logic next_lock
);

	logic advance;
	rename_pkg::capture_entry_t [rename_pkg::ISSUE_W-1:0] cap_entry;
	logic [rename_pkg::WORD_W-1:0] cap_pc;
	rename_pkg::arch_reg_t [2*rename_pkg::ISSUE_W-1:0] rd_idx;
	rename_pkg::phys_reg_t [2*rename_pkg::ISSUE_W-1:0] rd_phys;
	rename_pkg::map_write_t [rename_pkg::ISSUE_W-1:0] map_wr;

	// Lock, tag pops and first register
	rename_capture_stage u_capture (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.flush(flush),
		.prev_inst(prev_inst),
		.prev_pc(prev_pc),
		.prev_lock(prev_lock),
		.free_tag(free_tag),
		.free_empty(free_empty),
		.free_rd(free_rd),
		.next_lock(next_lock),
		.advance(advance),
		.cap_entry(cap_entry),
		.cap_pc(cap_pc)
	);

	rename_map_table u_map (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.restart(restart),
		.rd_idx(rd_idx),
		.rd_phys(rd_phys),
		.map_wr(map_wr)
	);

	// Lookup, bypass and output register
	rename_dispatch_stage u_dispatch (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.flush(flush),
		.advance(advance),
		.cap_entry(cap_entry),
		.cap_pc(cap_pc),
		.rd_idx(rd_idx),
		.rd_phys(rd_phys),
		.map_wr(map_wr),
		.next_inst(next_inst),
		.next_pc(next_pc)
	);

endmodule

`default_nettype wire

// File: include/rename_tb_model.svh
// Rename reference model
`ifndef RENAME_TB_MODEL_SVH
`define RENAME_TB_MODEL_SVH

	rename_pkg::phys_reg_t model_map [rename_pkg::ARCH_REGS];
	// Pairs taken by the capture stage, oldest first
	rename_pkg::capture_entry_t [rename_pkg::ISSUE_W-1:0] acc_pair [$];
	logic [rename_pkg::WORD_W-1:0] acc_pc [$];

	function automatic void reset_model();
		for (int i = 0; i < rename_pkg::ARCH_REGS; i++) begin
			model_map[i] = rename_pkg::phys_reg_t'(i);
		end
	endfunction

	// Slot 1 sees the new name slot 0 gives in the same pair
	function automatic rename_pkg::phys_reg_t source_name(
			input rename_pkg::capture_entry_t [rename_pkg::ISSUE_W-1:0] cap,
			input int k, input rename_pkg::arch_reg_t r);
		if (k == 1 && cap[0].inst.valid && cap[0].inst.writeback && cap[0].inst.dest == r) begin
			return cap[0].dest_tag;
		end
		return model_map[r];
	endfunction

	task automatic expect_pair(input rename_pkg::capture_entry_t [rename_pkg::ISSUE_W-1:0] cap,
			output rename_pkg::renamed_inst_t [rename_pkg::ISSUE_W-1:0] exp);
		for (int k = 0; k < rename_pkg::ISSUE_W; k++) begin
			exp[k] = '0;
			exp[k].valid = cap[k].inst.valid;
			exp[k].writeback = cap[k].inst.writeback;
			exp[k].src0_active = cap[k].inst.src0_active;
			exp[k].src1_active = cap[k].inst.src1_active;
			exp[k].src1_imm = cap[k].inst.src1_imm;
			exp[k].src0 = source_name(cap, k, cap[k].inst.src0);
			exp[k].src1 = cap[k].inst.src1;
			if (!cap[k].inst.src1_imm) begin
				exp[k].src1.imm = {26'b0, source_name(cap, k, cap[k].inst.src1.idx.num[4:0])};
			end
			exp[k].dest_logic = cap[k].inst.dest;
			exp[k].dest_phys = cap[k].dest_tag;
			exp[k].cmd = cap[k].inst.cmd;
			exp[k].ex_unit = cap[k].inst.ex_unit;
		end
		// Slot 1 last so it wins a shared register
		for (int k = 0; k < rename_pkg::ISSUE_W; k++) begin
			if (cap[k].inst.valid && cap[k].inst.writeback) begin
				model_map[cap[k].inst.dest] = cap[k].dest_tag;
			end
		end
	endtask

	// Dropped pairs give their tags back
	task automatic flush_model();
		rename_pkg::capture_entry_t [rename_pkg::ISSUE_W-1:0] cap;
		while (acc_pair.size() > 0) begin
			cap = acc_pair.pop_front();
			for (int k = 0; k < rename_pkg::ISSUE_W; k++) begin
				if (cap[k].inst.valid && cap[k].inst.writeback) begin
					schedule_recycle(cap[k].dest_tag);
				end
			end
		end
		acc_pc.delete();
		reset_model();
	endtask

`endif

// File: bench/rename_tb.sv
// Rename stage testbench
`default_nettype none

module rename_tb;

	localparam int RUN_CYCLES = 2000;
	localparam int RECYCLE_DELAY = 40;
	localparam int DRAIN_LIMIT = 100;

	logic iCLOCK;
	logic inRESET;
	logic flush;
	logic restart;
	rename_pkg::rename_inst_t [rename_pkg::ISSUE_W-1:0] prev_inst;
	logic [rename_pkg::WORD_W-1:0] prev_pc;
	logic prev_lock;
	rename_pkg::phys_reg_t [rename_pkg::ISSUE_W-1:0] free_tag;
	logic [rename_pkg::ISSUE_W-1:0] free_empty;
	logic [rename_pkg::ISSUE_W-1:0] free_rd;
	rename_pkg::renamed_inst_t [rename_pkg::ISSUE_W-1:0] next_inst;
	logic [rename_pkg::WORD_W-1:0] next_pc;
	logic next_lock;

	integer seed;
	int cycle;
	bit draining;
	// Free list channels and tags waiting to come back
	rename_pkg::phys_reg_t free_q0 [$];
	rename_pkg::phys_reg_t free_q1 [$];
	rename_pkg::phys_reg_t recycle_tag [$];
	int recycle_due [$];
	bit tag_busy [64];

	`include "rename_tb_model.svh"

	rename_top uut (.*);

	initial begin
		iCLOCK = 1'b0;
		forever begin
			#50 iCLOCK = ~iCLOCK;
		end
	end

	task automatic end_with_failure();
		$display("Simulation finished: FAIL");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic fail_value(input string msg);
		$display("FAIL at time %0t: %s", $time, msg);
		end_with_failure();
	endtask

	// Tags 48 and up belong to channel 1
	task automatic return_tag(input rename_pkg::phys_reg_t tag);
		if (tag >= 6'd48) begin
			free_q1.push_back(tag);
		end else begin
			free_q0.push_back(tag);
		end
	endtask

	task automatic schedule_recycle(input rename_pkg::phys_reg_t tag);
		recycle_tag.push_back(tag);
		recycle_due.push_back(cycle + RECYCLE_DELAY);
	endtask

	function automatic rename_pkg::rename_inst_t random_inst();
		rename_pkg::rename_inst_t inst;
		logic [31:0] r;
		logic [31:0] imm;
		r = $random(seed);
		imm = $random(seed);
		inst.valid = (r[1:0] != 2'b00);
		inst.writeback = r[2];
		inst.src0_active = r[3];
		inst.src1_active = r[4];
		inst.src1_imm = r[5];
		// Only eight registers so that pairs often share them
		inst.src0 = {2'b00, r[8:6]};
		inst.dest = {2'b00, r[11:9]};
		inst.src1.imm = r[5] ? imm : {29'b0, r[14:12]};
		inst.cmd = r[19:15];
		inst.ex_unit = 10'b1 << (r[23:20] % 4'd10);
		return inst;
	endfunction

	// Unused sources and non-writeback tags are don't care
	function automatic bit slot_matches(input rename_pkg::renamed_inst_t act,
			input rename_pkg::renamed_inst_t exp);
		if (!exp.valid) begin
			return !act.valid;
		end
		return act.valid && act.writeback == exp.writeback
			&& act.src0_active == exp.src0_active && act.src1_active == exp.src1_active
			&& act.src1_imm == exp.src1_imm && act.dest_logic == exp.dest_logic
			&& act.cmd == exp.cmd && act.ex_unit == exp.ex_unit
			&& (!exp.src0_active || act.src0 == exp.src0)
			&& (!(exp.src1_active || exp.src1_imm) || act.src1 == exp.src1)
			&& (!exp.writeback || act.dest_phys == exp.dest_phys);
	endfunction

	task automatic drive_inputs();
		logic [31:0] r;
		while (recycle_due.size() > 0) begin
			if (recycle_due[0] > cycle) begin
				break;
			end
			tag_busy[recycle_tag[0]] = 1'b0;
			return_tag(recycle_tag.pop_front());
			recycle_due.delete(0);
		end
		r = $random(seed);
		flush = !draining && (cycle % 500 == 250);
		restart = flush;
		next_lock = !draining && (r[2:0] == 3'b000);
		prev_pc = $random(seed);
		for (int k = 0; k < rename_pkg::ISSUE_W; k++) begin
			prev_inst[k] = random_inst();
			if (draining || flush) begin
				prev_inst[k].valid = 1'b0;
			end
		end
		// First word fall through heads
		free_empty[0] = (free_q0.size() == 0);
		free_empty[1] = (free_q1.size() == 0);
		free_tag = '0;
		if (!free_empty[0]) begin
			free_tag[0] = free_q0[0];
		end
		if (!free_empty[1]) begin
			free_tag[1] = free_q1[0];
		end
	endtask

	task automatic check_cycle();
		rename_pkg::capture_entry_t [rename_pkg::ISSUE_W-1:0] acc;
		rename_pkg::renamed_inst_t [rename_pkg::ISSUE_W-1:0] exp;
		logic [rename_pkg::WORD_W-1:0] pc_exp;
		logic [rename_pkg::ISSUE_W-1:0] rd_exp;
		logic lock_exp;
		lock_exp = (|free_empty) | next_lock;
		for (int k = 0; k < rename_pkg::ISSUE_W; k++) begin
			rd_exp[k] = prev_inst[k].valid && prev_inst[k].writeback && !lock_exp;
		end
		assert (prev_lock == lock_exp)
			else fail_value($sformatf("prev_lock %b, expected %b", prev_lock, lock_exp));
		assert (free_rd == rd_exp)
			else fail_value($sformatf("free_rd %b, expected %b", free_rd, rd_exp));
		assert (!lock_exp || !(next_inst[0].valid || next_inst[1].valid))
			else fail_value("next_inst valid during a stall");
		// A pair shown in a flush cycle is dropped
		if (!flush && (next_inst[0].valid || next_inst[1].valid)) begin
			assert (acc_pair.size() > 0) else fail_value("renamed pair with nothing in flight");
			pc_exp = acc_pc.pop_front();
			expect_pair(acc_pair.pop_front(), exp);
			assert (next_pc == pc_exp)
				else fail_value($sformatf("next_pc %h, expected %h", next_pc, pc_exp));
			for (int k = 0; k < rename_pkg::ISSUE_W; k++) begin
				if (exp[k].valid && exp[k].writeback && next_inst[k].valid) begin
					assert (!tag_busy[next_inst[k].dest_phys])
						else fail_value($sformatf("tag %0d in use twice",
							next_inst[k].dest_phys));
				end
				assert (slot_matches(next_inst[k], exp[k]))
					else fail_value($sformatf("slot %0d is %h, expected %h",
						k, next_inst[k], exp[k]));
				if (exp[k].valid && exp[k].writeback) begin
					tag_busy[exp[k].dest_phys] = 1'b1;
					schedule_recycle(exp[k].dest_phys);
				end
			end
		end
		if (!lock_exp && (prev_inst[0].valid || prev_inst[1].valid)) begin
			for (int k = 0; k < rename_pkg::ISSUE_W; k++) begin
				acc[k].inst = prev_inst[k];
				acc[k].dest_tag = '0;
			end
			if (rd_exp[0]) begin
				acc[0].dest_tag = free_q0.pop_front();
			end
			if (rd_exp[1]) begin
				acc[1].dest_tag = free_q1.pop_front();
			end
			acc_pair.push_back(acc);
			acc_pc.push_back(prev_pc);
		end
		if (flush) begin
			flush_model();
		end
	endtask

	task automatic step_cycle();
		@(posedge iCLOCK);
		#5;
		cycle++;
		drive_inputs();
		@(negedge iCLOCK);
		check_cycle();
	endtask

	initial begin
		int wait_count;
		seed = 50453;
		cycle = 0;
		draining = 1'b0;
		inRESET = 1'b1;
		flush = 1'b0;
		restart = 1'b0;
		prev_inst = '0;
		prev_pc = '0;
		free_tag = '0;
		free_empty = '0;
		next_lock = 1'b0;
		for (int t = 32; t < 64; t++) begin
			return_tag(rename_pkg::phys_reg_t'(t));
		end
		reset_model();
		#10 inRESET = 1'b0;
		repeat (5) @(posedge iCLOCK);
		#5 inRESET = 1'b1;
		while (cycle < RUN_CYCLES) begin
			step_cycle();
		end
		// Stop issuing and let every pair in flight come out
		draining = 1'b1;
		wait_count = 0;
		while (acc_pair.size() > 0) begin
			if (wait_count > DRAIN_LIMIT) begin
				$display("Timeout: renamed pairs still in flight after the drain limit");
				end_with_failure();
			end else begin
				step_cycle();
				wait_count++;
			end
		end
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: rename.f
+incdir+include
hw/rename_pkg.sv
hw/rename_capture_stage.sv
hw/rename_map_table.sv
hw/rename_dispatch_stage.sv
hw/rename_top.sv
bench/rename_tb.sv

// File: Makefile
# Verilator build and run for the rename stage

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f rename.f --top-module rename_tb \
		-Mdir obj_dir -o rename_sim

run: compile
	-./obj_dir/rename_sim > sim.log 2>&1
	cat sim.log
	! grep -q "Simulation finished: FAIL" sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
